/* hw/sd_cmd_cfg.svh */
// configuration macros of the SD command path
// queue depth, card clock divider, response timeout, register map

`ifndef SD_CMD_CFG_SVH
`define SD_CMD_CFG_SVH

`default_nettype none

// queue slots, one bus credit per slot
`define CMD_QUEUE_DEPTH 4

`define SD_CLK_DIV      4   // clk cycles per sd_clk half period
`define RESP_TIMEOUT    64  // sd_clk periods up to the response start bit

// word addresses on the host bus
`define REG_ARG         4'd0
`define REG_CMD         4'd1
`define REG_RESP        4'd2
`define REG_STATUS      4'd3

`default_nettype wire

`endif

/* hw/sd_cmd_pkg.sv */
// shared types of the SD command path
// token union, queue entry, response record, status bit map, CRC7 step

`default_nettype none

package sd_cmd_pkg;

   ////////////////////////////////////////
   // 48-bit command / response token
   ////////////////////////////////////////
   typedef struct packed {
      logic        start;   // always 0
      logic        dir;     // 1 host to card
      logic [5:0]  index;
      logic [31:0] arg;
      logic [6:0]  crc;
      logic        stop;    // end bit, always 1
   } sd_fields_t;

   typedef union packed {
      sd_fields_t  f;
      logic [47:0] raw;     // shift view, MSB goes out first
   } sd_token_t;

   typedef struct packed {
      logic [5:0]  index;
      logic [31:0] arg;
   } cmd_entry_t;

   typedef struct packed {
      logic [5:0]  index;
      logic [31:0] arg;
      logic        timeout;
      logic        crc_error;
      logic        index_error;
   } resp_info_t;

   // status register layout
   localparam int STAT_COMPLETE     = 0;
   localparam int STAT_TIMEOUT      = 1;
   localparam int STAT_CRC_ERR      = 2;
   localparam int STAT_INDEX_ERR    = 3;
   localparam int STAT_REJECTED     = 4;
   localparam int STAT_CREDIT_LSB   = 8;
   localparam int STAT_CREDIT_MSB   = 11;
   localparam int STAT_RESP_IDX_LSB = 16;
   localparam int STAT_RESP_IDX_MSB = 21;

   // one bit of CRC7, x^7 + x^3 + 1
   function automatic logic [6:0] crc7_step(input logic [6:0] crc, input logic din);
      logic fb;
      fb = crc[6] ^ din;
      crc7_step = {crc[5:0], 1'b0} ^ (fb ? 7'h09 : 7'h00);
   endfunction

endpackage

`default_nettype wire

/* hw/cmd_link_if.sv */
// links inside the SD command path
// cmd_req_if: register bank to queue, requests and credits
// cmd_res_if: queue and register bank to line engine, tokens and results

`timescale 1ns/1ps
`default_nettype none

interface cmd_req_if;
   logic                   req_valid;     // one cycle per command
   sd_cmd_pkg::cmd_entry_t req_entry;
   logic                   credit_return; // one cycle per finished command

   modport regs_side  (output req_valid, req_entry, input credit_return);
   modport queue_side (input req_valid, req_entry, output credit_return);
endinterface

interface cmd_res_if;
   logic                   tok_valid;
   sd_cmd_pkg::sd_token_t  tok;
   logic                   phy_busy;
   logic                   done;          // one cycle, result valid
   sd_cmd_pkg::resp_info_t result;

   modport queue_side (output tok_valid, tok, input phy_busy, done);
   modport phy_side   (input tok_valid, tok, output phy_busy, done, result);
   modport regs_side  (input done, result);
endinterface

`default_nettype wire

/* hw/sd_host_regs.sv */
// host register bank of the SD command path
// argument, response and status registers, credit counter, irq

`timescale 1ns/1ps
`include "sd_cmd_cfg.svh"
`default_nettype none

module sd_host_regs (
   input  wire logic        clk,
   input  wire logic        rst_n,
   input  wire logic [3:0]  addrs,
   input  wire logic        wr_en,
   input  wire logic [31:0] wr_data,
   output logic      [31:0] rd_data,
   output logic             irq,
   cmd_req_if.regs_side     req,
   cmd_res_if.regs_side     res
);

   localparam int CRED_W = $clog2(`CMD_QUEUE_DEPTH + 1);

   logic [31:0]       arg_q;
   logic [31:0]       resp_arg_q;
   logic [5:0]        resp_idx_q;
   logic [4:0]        flags_q;     // sticky, cleared by writing ones
   logic [CRED_W-1:0] credits;
   logic              cmd_wr;
   logic              issue;
   logic              stat_wr;
   logic [4:0]        set_mask;
   logic [4:0]        clr_mask;
   logic [31:0]       status;

   assign cmd_wr  = wr_en && (addrs == `REG_CMD);
   assign stat_wr = wr_en && (addrs == `REG_STATUS);
   assign issue   = cmd_wr && (credits != '0);   // only with a free slot

   ////////////////////////////////////////
   // bus writes and request launch
   ////////////////////////////////////////
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         arg_q         <= '0;
         req.req_valid <= 1'b0;
      end else begin
         req.req_valid <= issue;
         if (wr_en && addrs == `REG_ARG)
            arg_q <= wr_data;
      end
   end

   always_ff @(posedge clk) begin
      if (issue) begin
         req.req_entry.index <= wr_data[5:0];
         req.req_entry.arg   <= arg_q;
      end
   end

   // credits, one per queue slot
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         credits <= CRED_W'(`CMD_QUEUE_DEPTH);
      end else begin
         case ({issue, req.credit_return})
            2'b10:   credits <= credits - 1'b1;
            2'b01:   credits <= credits + 1'b1;
            default: credits <= credits;  // none, or one out and one back
         endcase
      end
   end

   ////////////////////////////////////////
   // status flags and response capture
   ////////////////////////////////////////
   always_comb begin
      set_mask = '0;
      set_mask[sd_cmd_pkg::STAT_COMPLETE]  = res.done;
      set_mask[sd_cmd_pkg::STAT_TIMEOUT]   = res.done && res.result.timeout;
      set_mask[sd_cmd_pkg::STAT_CRC_ERR]   = res.done && res.result.crc_error;
      set_mask[sd_cmd_pkg::STAT_INDEX_ERR] = res.done && res.result.index_error;
      set_mask[sd_cmd_pkg::STAT_REJECTED]  = cmd_wr && (credits == '0);
      clr_mask = stat_wr ? wr_data[4:0] : 5'b0;
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         flags_q    <= '0;
         resp_arg_q <= '0;
         resp_idx_q <= '0;
      end else begin
         flags_q <= (flags_q & ~clr_mask) | set_mask;  // set wins
         if (res.done && !res.result.timeout) begin
            resp_arg_q <= res.result.arg;
            resp_idx_q <= res.result.index;
         end
      end
   end

   assign irq = |flags_q;

   // read side
   always_comb begin
      status = '0;
      status[sd_cmd_pkg::STAT_REJECTED:sd_cmd_pkg::STAT_COMPLETE] = flags_q;
      status[sd_cmd_pkg::STAT_CREDIT_MSB:sd_cmd_pkg::STAT_CREDIT_LSB] = 4'(credits);
      status[sd_cmd_pkg::STAT_RESP_IDX_MSB:sd_cmd_pkg::STAT_RESP_IDX_LSB] = resp_idx_q;
      case (addrs)
         `REG_ARG:    rd_data = arg_q;
         `REG_RESP:   rd_data = resp_arg_q;
         `REG_STATUS: rd_data = status;
         default:     rd_data = '0;   // REG_CMD is write only
      endcase
   end

endmodule

`default_nettype wire

/* hw/cmd_queue_crc.sv */
// command queue with CRC7 and token builder
// circular buffer of entries, registered token stage, credit return

`timescale 1ns/1ps
`include "sd_cmd_cfg.svh"
`default_nettype none

module cmd_queue_crc (
   input wire logic      clk,
   input wire logic      rst_n,
   cmd_req_if.queue_side req,
   cmd_res_if.queue_side res
);

   localparam int PTR_W = $clog2(`CMD_QUEUE_DEPTH);
   localparam int CNT_W = $clog2(`CMD_QUEUE_DEPTH + 1);

   sd_cmd_pkg::cmd_entry_t mem [`CMD_QUEUE_DEPTH];
   logic [PTR_W-1:0]       wr_ptr;
   logic [PTR_W-1:0]       rd_ptr;
   logic [CNT_W-1:0]       count;
   sd_cmd_pkg::cmd_entry_t head;
   logic                   tok_loaded;    // output stage holds the head token
   logic                   take;          // phy accepts this cycle
   logic [39:0]            crc_bits;
   logic [6:0]             crc_calc;
   sd_cmd_pkg::sd_token_t  tok_next;
   sd_cmd_pkg::sd_token_t  tok_q;

   assign head = mem[rd_ptr];
   assign take = res.tok_valid;

   ////////////////////////////////////////
   // circular buffer
   ////////////////////////////////////////
   always_ff @(posedge clk) begin
      if (req.req_valid)
         mem[wr_ptr] <= req.req_entry;
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (req.req_valid)
            wr_ptr <= wr_ptr + 1'b1;   // credits keep this off a full queue
         if (take)
            rd_ptr <= rd_ptr + 1'b1;
         count <= count + CNT_W'(req.req_valid) - CNT_W'(take);
      end
   end

   // token of the head entry, CRC over the first 40 bits
   always_comb begin
      crc_bits = {1'b0, 1'b1, head.index, head.arg};
      crc_calc = '0;
      for (int i = 39; i >= 0; i--)
         crc_calc = sd_cmd_pkg::crc7_step(crc_calc, crc_bits[i]);
      tok_next.f.start = 1'b0;
      tok_next.f.dir   = 1'b1;
      tok_next.f.index = head.index;
      tok_next.f.arg   = head.arg;
      tok_next.f.crc   = crc_calc;
      tok_next.f.stop  = 1'b1;
   end

   ////////////////////////////////////////
   // output stage
   ////////////////////////////////////////
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n)
         tok_loaded <= 1'b0;
      else if (take)
         tok_loaded <= 1'b0;
      else if (!tok_loaded && count != '0)
         tok_loaded <= 1'b1;
   end

   always_ff @(posedge clk) begin
      if (!tok_loaded)
         tok_q <= tok_next;
   end

   assign res.tok_valid = tok_loaded && !res.phy_busy;
   assign res.tok       = tok_q;

   assign req.credit_return = res.done;  // slot is free once the command is over

endmodule

`default_nettype wire

/* hw/cmd_line_phy.sv */
// command line engine
// sd_clk divider, token serializer, response receiver with timeout,
// CRC7 and index checks of the R1 response

`timescale 1ns/1ps
`include "sd_cmd_cfg.svh"
`default_nettype none

module cmd_line_phy (
   input  wire logic   clk,
   input  wire logic   rst_n,
   input  wire logic   cmd_in,
   output logic        sd_clk,
   output logic        cmd_out,
   output logic        cmd_oe,
   cmd_res_if.phy_side res
);

   localparam int DIV_W = $clog2(`SD_CLK_DIV);
   localparam int TMO_W = $clog2(`RESP_TIMEOUT);

   typedef enum logic [1:0] {S_IDLE, S_SEND, S_WAIT, S_RECV} phy_state_t;

   phy_state_t             state;
   logic [DIV_W-1:0]       div_cnt;
   logic                   sd_clk_q;
   logic                   tick;
   logic                   rise;
   logic                   fall;
   logic                   tmo_last;
   logic                   rx_last;
   logic                   finish;
   logic [5:0]             bit_cnt;    // tx and rx bit position
   logic [TMO_W-1:0]       tmo_cnt;
   logic [47:0]            tx_sr;
   sd_cmd_pkg::sd_token_t  rx_tok;
   sd_cmd_pkg::sd_token_t  rx_word;
   logic [6:0]             rx_crc;
   logic [5:0]             sent_idx;
   logic                   cmd_out_q;
   logic                   cmd_oe_q;
   logic                   done_q;
   sd_cmd_pkg::resp_info_t result_q;

   assign tick     = (state != S_IDLE) && (div_cnt == DIV_W'(`SD_CLK_DIV - 1));
   assign rise     = tick && !sd_clk_q;
   assign fall     = tick && sd_clk_q;
   assign tmo_last = (state == S_WAIT) && cmd_in && (tmo_cnt == TMO_W'(`RESP_TIMEOUT - 1));
   assign rx_last  = (state == S_RECV) && (bit_cnt == 6'd47);
   assign finish   = rise && (tmo_last || rx_last);

   assign rx_word.raw = {rx_tok.raw[46:0], cmd_in};

   ////////////////////////////////////////
   // card clock, runs only while busy
   ////////////////////////////////////////
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         sd_clk_q <= 1'b0;
         div_cnt  <= '0;
      end else if (state == S_IDLE || finish) begin
         sd_clk_q <= 1'b0;    // park low, no edge at the end
         div_cnt  <= '0;
      end else if (tick) begin
         sd_clk_q <= !sd_clk_q;
         div_cnt  <= '0;
      end else begin
         div_cnt <= div_cnt + 1'b1;
      end
   end

   ////////////////////////////////////////
   // line FSM
   ////////////////////////////////////////
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state     <= S_IDLE;
         cmd_oe_q  <= 1'b0;
         cmd_out_q <= 1'b1;
         done_q    <= 1'b0;
         bit_cnt   <= '0;
         tmo_cnt   <= '0;
      end else begin
         done_q <= 1'b0;
         case (state)
            S_IDLE: if (res.tok_valid) begin
               state     <= S_SEND;
               cmd_oe_q  <= 1'b1;
               cmd_out_q <= res.tok.raw[47];  // start bit
               bit_cnt   <= '0;
            end
            S_SEND: if (fall) begin
               if (bit_cnt == 6'd47) begin  // end bit was sampled
                  state     <= S_WAIT;
                  cmd_oe_q  <= 1'b0;
                  cmd_out_q <= 1'b1;
                  tmo_cnt   <= '0;
               end else begin
                  cmd_out_q <= tx_sr[46];
                  bit_cnt   <= bit_cnt + 1'b1;
               end
            end
            S_WAIT: if (rise) begin
               if (!cmd_in) begin
                  state   <= S_RECV;
                  bit_cnt <= 6'd1;
               end else if (tmo_last) begin
                  state  <= S_IDLE;
                  done_q <= 1'b1;
               end else begin
                  tmo_cnt <= tmo_cnt + 1'b1;
               end
            end
            S_RECV: if (rise) begin
               bit_cnt <= bit_cnt + 1'b1;
               if (rx_last) begin
                  state  <= S_IDLE;
                  done_q <= 1'b1;
               end
            end
            default: state <= S_IDLE;
         endcase
      end
   end

   // shift registers, CRC and result record
   always_ff @(posedge clk) begin
      if (state == S_IDLE && res.tok_valid) begin
         tx_sr    <= res.tok.raw;
         sent_idx <= res.tok.f.index;
      end else if (state == S_SEND && fall) begin
         tx_sr <= {tx_sr[46:0], 1'b0};
      end
      if (rise && state == S_WAIT && !cmd_in) begin
         rx_tok.raw <= rx_word.raw;
         rx_crc     <= sd_cmd_pkg::crc7_step(7'd0, 1'b0);
      end else if (rise && state == S_RECV) begin
         rx_tok.raw <= rx_word.raw;
         if (bit_cnt < 6'd40)
            rx_crc <= sd_cmd_pkg::crc7_step(rx_crc, cmd_in);
      end
      if (rise && tmo_last) begin
         result_q         <= '0;
         result_q.timeout <= 1'b1;
      end else if (rise && rx_last) begin
         result_q.index       <= rx_word.f.index;
         result_q.arg         <= rx_word.f.arg;
         result_q.timeout     <= 1'b0;
         result_q.crc_error   <= rx_word.f.crc != rx_crc;
         result_q.index_error <= rx_word.f.index != sent_idx;
      end
   end

   assign sd_clk       = sd_clk_q;
   assign cmd_out      = cmd_out_q;
   assign cmd_oe       = cmd_oe_q;
   assign res.phy_busy = state != S_IDLE;
   assign res.done     = done_q;
   assign res.result   = result_q;

endmodule

`default_nettype wire

/* hw/sd_cmd_host.sv */
// top level of the SD host command path
// register bank, command queue and line engine on two internal links

`timescale 1ns/1ps
`default_nettype none

module sd_cmd_host (
   input  wire logic        clk,
   input  wire logic        rst_n,
   // host bus, word addressed
   input  wire logic [3:0]  addrs,
   input  wire logic        wr_en,
   input  wire logic [31:0] wr_data,
   output logic      [31:0] rd_data,
   // card command line
   output logic             sd_clk,
   output logic             cmd_out,
   output logic             cmd_oe,
   input  wire logic        cmd_in,
   output logic             irq
);

   cmd_req_if req_link ();   // regs to queue
   cmd_res_if res_link ();   // tokens and results

   sd_host_regs u_regs (
      .clk     (clk),
      .rst_n   (rst_n),
      .addrs   (addrs),
      .wr_en   (wr_en),
      .wr_data (wr_data),
      .rd_data (rd_data),
      .irq     (irq),
      .req     (req_link.regs_side),
      .res     (res_link.regs_side)
   );

   cmd_queue_crc u_queue (
      .clk   (clk),
      .rst_n (rst_n),
      .req   (req_link.queue_side),
      .res   (res_link.queue_side)
   );

   cmd_line_phy u_phy (
      .clk     (clk),
      .rst_n   (rst_n),
      .cmd_in  (cmd_in),
      .sd_clk  (sd_clk),
      .cmd_out (cmd_out),
      .cmd_oe  (cmd_oe),
      .res     (res_link.phy_side)
   );

endmodule

`default_nettype wire

/* test/sd_cmd_asserts.sv */
// concurrent checks on the SD command path top level
// card clock activity while driving, credit bound, irq after reset

`timescale 1ns/1ps
`include "sd_cmd_cfg.svh"
`default_nettype none

module sd_cmd_asserts (
   input wire logic        clk,
   input wire logic        rst_n,
   input wire logic [3:0]  addrs,
   input wire logic [31:0] rd_data,
   input wire logic        sd_clk,
   input wire logic        cmd_oe,
   input wire logic        irq
);

   localparam int STALL_MAX = 2 * `SD_CLK_DIV;   // one full sd_clk period

   logic       sd_clk_d;
   logic [7:0] oe_stall;   // cycles with cmd_oe high and no sd_clk edge

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         sd_clk_d <= 1'b0;
         oe_stall <= '0;
      end else begin
         sd_clk_d <= sd_clk;
         if (!cmd_oe || sd_clk != sd_clk_d)
            oe_stall <= '0;
         else if (oe_stall != 8'hFF)
            oe_stall <= oe_stall + 1'b1;
      end
   end

   oe_needs_clock: assert property (@(posedge clk) disable iff (!rst_n)
      oe_stall <= 8'(STALL_MAX))
      else $error("cmd_oe is high while sd_clk is stopped");

   // credit field of the status word
   credit_bound: assert property (@(posedge clk) disable iff (!rst_n)
      (addrs == `REG_STATUS) |->
         (rd_data[sd_cmd_pkg::STAT_CREDIT_MSB:sd_cmd_pkg::STAT_CREDIT_LSB]
          <= 4'(`CMD_QUEUE_DEPTH)))
      else $error("credit count is above the queue depth");

   irq_quiet_after_reset: assert property (@(posedge clk) $rose(rst_n) |=> !irq)
      else $error("irq is high right after reset release");

endmodule

bind sd_cmd_host sd_cmd_asserts u_asserts (
   .clk     (clk),
   .rst_n   (rst_n),
   .addrs   (addrs),
   .rd_data (rd_data),
   .sd_clk  (sd_clk),
   .cmd_oe  (cmd_oe),
   .irq     (irq)
);

`default_nettype wire

/* test/tb_sd_cmd_host.sv */
// testbench of the SD host command path
// card model, stimulus table, register checks, back-pressure run

`timescale 1ns/1ps
`include "sd_cmd_cfg.svh"
`default_nettype none

module tb_sd_cmd_host;

   localparam int ROWS         = 6;
   localparam int MODE_ANSWER  = 0;
   localparam int MODE_SILENT  = 1;
   localparam int MODE_BAD_CRC = 2;
   localparam int WAIT_LIMIT   = 20000;  // clk cycles per wait
   localparam int BP_IDX       = 20;     // first index of the back-pressure burst

   logic        clk;
   logic        rst_n;
   logic [3:0]  addrs;
   logic        wr_en;
   logic [31:0] wr_data;
   logic [31:0] rd_data;
   logic        sd_clk;
   logic        cmd_out;
   logic        cmd_oe;
   logic        cmd_in;
   logic        irq;

   int          errors;
   int          timeouts;
   integer      seed;
   logic [47:0] seen_frames[$];   // tokens as the card decoded them
   logic [31:0] last_resp;
   logic [5:0]  last_idx;

   // stimulus table, flags are rejected, index_err, crc_err, timeout, complete
   logic [5:0]  tbl_idx   [ROWS];
   logic [31:0] tbl_arg   [ROWS];
   int          tbl_mode  [ROWS];
   logic [4:0]  tbl_flags [ROWS];

   sd_cmd_host uut (
      .clk     (clk),
      .rst_n   (rst_n),
      .addrs   (addrs),
      .wr_en   (wr_en),
      .wr_data (wr_data),
      .rd_data (rd_data),
      .sd_clk  (sd_clk),
      .cmd_out (cmd_out),
      .cmd_oe  (cmd_oe),
      .cmd_in  (cmd_in),
      .irq     (irq)
   );

   always #4 clk = ~clk;

   ////////////////////////////////////////
   // helpers
   ////////////////////////////////////////
   task automatic step_clk();
      @(posedge clk);
      #1;   // outputs settled, inputs change here
   endtask

   task automatic check_val(input logic [47:0] got, input logic [47:0] exp, input string what);
      if (got !== exp) begin
         errors++;
         $display("error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
      end
   endtask

   // remainder of msg * x^7 divided by x^7 + x^3 + 1
   function automatic logic [6:0] crc7_div(input logic [39:0] msg);
      logic [46:0] rem;
      rem = {msg, 7'b0};
      for (int i = 46; i >= 7; i--) begin
         if (rem[i])
            rem[i -: 8] = rem[i -: 8] ^ 8'h89;
      end
      return rem[6:0];
   endfunction

   function automatic logic [47:0] expected_token(input logic [5:0] idx, input logic [31:0] arg);
      logic [39:0] body;
      body = {2'b01, idx, arg};
      return {body, crc7_div(body), 1'b1};
   endfunction

   task automatic bus_write(input logic [3:0] a, input logic [31:0] d);
      addrs   = a;
      wr_en   = 1'b1;
      wr_data = d;
      step_clk();
      wr_en   = 1'b0;
   endtask

   task automatic bus_read(input logic [3:0] a, output logic [31:0] d);
      addrs = a;
      step_clk();
      d = rd_data;
   endtask

   task automatic wait_sd_edge(input logic level, input string what);
      logic prev;
      bit   found;
      found = 1'b0;
      for (int n = 0; n < WAIT_LIMIT && !found; n++) begin
         prev = sd_clk;
         step_clk();
         found = (prev !== level) && (sd_clk === level);
      end
      if (!found) begin
         timeouts++;
         $display("timeout: sd_clk did not %s while %s", level ? "rise" : "fall", what);
      end
   endtask

   task automatic wait_cmd_oe();
      bit found;
      found = (cmd_oe === 1'b1);
      for (int n = 0; n < WAIT_LIMIT && !found; n++) begin
         step_clk();
         found = (cmd_oe === 1'b1);
      end
      if (!found) begin
         timeouts++;
         $display("timeout: the card never saw cmd_oe go high");
      end
   endtask

   task automatic wait_status(input int field_lsb, input logic [3:0] value, input string what);
      logic [31:0] st;
      bit          found;
      found = 1'b0;
      for (int n = 0; n < WAIT_LIMIT && !found; n++) begin
         bus_read(`REG_STATUS, st);
         found = (field_lsb == 0) ? (st[0] === value[0]) : (st[11:8] === value);
      end
      if (!found) begin
         timeouts++;
         $display("timeout: status never showed the end of %s", what);
      end
   endtask

   ////////////////////////////////////////
   // card model
   ////////////////////////////////////////
   task automatic serve_frame(input int mode);
      logic [47:0] frame;
      logic [47:0] resp;
      logic [39:0] body;
      frame = '0;
      wait_cmd_oe();
      for (int i = 0; i < 48; i++) begin
         wait_sd_edge(1'b1, "the card reads a command");
         check_val(cmd_oe, 1, "cmd_oe during a command bit");
         frame = {frame[46:0], cmd_out};
      end
      seen_frames.push_back(frame);
      if (mode != MODE_SILENT) begin
         repeat (2) wait_sd_edge(1'b1, "the card delays its response");
         body = {2'b00, frame[45:40], ~frame[39:8]};
         resp = {body, crc7_div(body), 1'b1};
         if (mode == MODE_BAD_CRC)
            resp[1] = ~resp[1];   // lsb of the crc field
         for (int i = 47; i >= 0; i--) begin
            wait_sd_edge(1'b0, "the card sends a response");
            cmd_in = resp[i];
         end
         repeat (`SD_CLK_DIV + 1) step_clk();   // end bit taken by now
         cmd_in = 1'b1;
      end
   endtask

   ////////////////////////////////////////
   // test steps
   ////////////////////////////////////////
   task automatic set_row(input int r, input logic [5:0] idx, input logic [31:0] arg,
                          input int mode, input logic [4:0] flags);
      tbl_idx[r]   = idx;
      tbl_arg[r]   = arg;
      tbl_mode[r]  = mode;
      tbl_flags[r] = flags;
   endtask

   task automatic load_table();
      set_row(0, 6'd0,  32'h0000_0000, MODE_ANSWER,  5'b00001);
      set_row(1, 6'd8,  32'h0000_01AA, MODE_ANSWER,  5'b00001);
      set_row(2, 6'd55, $random(seed), MODE_ANSWER,  5'b00001);
      set_row(3, 6'd17, $random(seed), MODE_SILENT,  5'b00011);
      set_row(4, 6'd24, $random(seed), MODE_BAD_CRC, 5'b00101);
      set_row(5, 6'd13, $random(seed), MODE_ANSWER,  5'b00001);
   endtask

   task automatic check_reset();
      logic [31:0] st;
      check_val(cmd_oe, 0, "cmd_oe after reset");
      check_val(irq, 0, "irq after reset");
      check_val(sd_clk, 0, "sd_clk after reset");
      check_val(cmd_out, 1, "cmd_out after reset");
      bus_read(`REG_STATUS, st);
      check_val(st[4:0], 0, "status flags after reset");
      check_val(st[11:8], 4, "credits after reset");
   endtask

   // status and response after a command, then clear the flags
   task automatic check_result(input logic [4:0] flags, input string tag);
      logic [31:0] st;
      logic [31:0] resp;
      bus_read(`REG_STATUS, st);
      check_val(st[4:0], flags, {tag, " status flags"});
      check_val(st[11:8], 4, {tag, " credits"});
      check_val(st[21:16], last_idx, {tag, " response index"});
      bus_read(`REG_RESP, resp);
      check_val(resp, last_resp, {tag, " response argument"});
      check_val(irq, 1, {tag, " irq with flags set"});
      bus_write(`REG_STATUS, 32'h0000_001F);
      bus_read(`REG_STATUS, st);
      check_val(st[4:0], 0, {tag, " flags after clear"});
      check_val(irq, 0, {tag, " irq after clear"});
   endtask

   task automatic run_row(input int r);
      string tag;
      tag = $sformatf("row %0d", r);
      seen_frames.delete();
      fork
         serve_frame(tbl_mode[r]);
         begin
            bus_write(`REG_ARG, tbl_arg[r]);
            bus_write(`REG_CMD, {26'd0, tbl_idx[r]});
            wait_status(0, 4'd1, tag);
         end
      join
      check_val(seen_frames.size(), 1, {tag, " frames seen by the card"});
      if (seen_frames.size() == 1)
         check_val(seen_frames[0], expected_token(tbl_idx[r], tbl_arg[r]), {tag, " token"});
      if (tbl_mode[r] != MODE_SILENT) begin
         last_resp = ~tbl_arg[r];
         last_idx  = tbl_idx[r];
      end
      check_result(tbl_flags[r], tag);
   endtask

   task automatic run_backpressure();
      logic [31:0] st;
      logic [31:0] arg;
      arg = $random(seed);
      seen_frames.delete();
      bus_write(`REG_ARG, arg);
      fork
         repeat (4) serve_frame(MODE_ANSWER);
         begin
            for (int i = 0; i < 6; i++)
               bus_write(`REG_CMD, 32'(BP_IDX + i));
            bus_read(`REG_STATUS, st);
            check_val(st[11:8], 0, "credits right after six writes");
            check_val(st[4], 1, "rejected flag after six writes");
            wait_status(8, 4'd4, "the back-pressure burst");
         end
      join
      check_val(seen_frames.size(), 4, "frames seen by the card in the burst");
      if (seen_frames.size() == 4) begin
         for (int i = 0; i < 4; i++)
            check_val(seen_frames[i], expected_token(6'(BP_IDX + i), arg),
                      $sformatf("burst token %0d", i));
      end
      last_resp = ~arg;
      last_idx  = 6'(BP_IDX + 3);
      check_result(5'b10001, "burst");
   endtask

   initial begin
      clk       = 1'b0;
      rst_n     = 1'b0;
      addrs     = '0;
      wr_en     = 1'b0;
      wr_data   = '0;
      cmd_in    = 1'b1;   // line idles high
      errors    = 0;
      timeouts  = 0;
      seed      = 32'h3837_6097;
      last_resp = '0;
      last_idx  = '0;
      load_table();
      repeat (8) @(posedge clk);
      #1;
      rst_n = 1'b1;
      check_reset();
      for (int r = 0; r < ROWS; r++)
         run_row(r);
      run_backpressure();
      $display("errors: %0d, timeouts: %0d", errors, timeouts);
      if (errors == 0 && timeouts == 0)
         $display("TEST OK");
      else
         $display("TEST FAILED");
      $finish;
   end

endmodule

`default_nettype wire

/* list.f */
+incdir+hw
hw/sd_cmd_pkg.sv
hw/cmd_link_if.sv
hw/sd_host_regs.sv
hw/cmd_queue_crc.sv
hw/cmd_line_phy.sv
hw/sd_cmd_host.sv
test/sd_cmd_asserts.sv
test/tb_sd_cmd_host.sv

/* run_sim.sh */
#!/bin/sh
# build and run the SD command path testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
   -f list.f --top-module tb_sd_cmd_host -Mdir obj_dir -o sim_tb
if [ $? -ne 0 ]; then
   echo "build failed"
   exit 1
fi

out=$(./obj_dir/sim_tb)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if printf '%s\n' "$out" | grep -qx "TEST OK"; then
   exit 0
fi
exit 1
